/* files.f */
hw/mips_isa_pkg.sv
hw/mips_core_pkg.sv
hw/pc_unit.sv
hw/control_unit.sv
hw/register_file.sv
hw/alu.sv
hw/data_memory.sv
hw/mips_single_cycle.sv
test/tb_mips_single_cycle.sv

/* hw/alu.sv */
module alu
    import mips_core_pkg::*;
(
    input  alu_op_e     op,
    input  logic        alu_src,
    input  logic        imm_zext,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [15:0] imm,
    output logic [31:0] result,
    output logic        zero
);

    logic [31:0] imm_ext;
    logic [31:0] op_b;

    // ori zero-extends, everything else sign-extends
    assign imm_ext = imm_zext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
    assign op_b    = alu_src ? imm_ext : b;

    always_comb begin
        case (op)
            ALU_ADD: result = a + op_b;
            ALU_SUB: result = a - op_b;
            ALU_AND: result = a & op_b;
            ALU_OR:  result = a | op_b;
            ALU_SLT: result = {31'd0, $signed(a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    // beq compares through ALU_SUB
    assign zero = (result == '0);

endmodule

/* hw/control_unit.sv */
module control_unit
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  opcode_e opcode,
    input  funct_e  funct,
    output ctrl_t   ctrl
);

    always_comb begin
        // Safe default, no state changes
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;

        case (opcode)
            R_TYPE: begin
                ctrl.reg_dst = 1'b1;
                case (funct)
                    ADD: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_ADD;
                    end
                    SUB: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_SUB;
                    end
                    AND: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_AND;
                    end
                    OR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_OR;
                    end
                    SLT: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_SLT;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            ORI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.imm_zext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
            end
            LW: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            J:       ctrl.jump = 1'b1;
            default: ctrl.jump = 1'b0;
        endcase
    end

endmodule

/* hw/data_memory.sv */
module data_memory
    import mips_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata
);

    logic [31:0]           mem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] idx;

    // Word index, wraps modulo DMEM_WORDS
    assign idx   = addr[2 +: DMEM_IDX_W];
    assign rdata = mem[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> addr[1:0] == 2'b00);

endmodule

/* hw/mips_core_pkg.sv */
package mips_core_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic    reg_dst;
        logic    alu_src;
        logic    imm_zext;
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_write;
        logic    branch;
        logic    jump;
        alu_op_e alu_op;
    } ctrl_t;

    // Register write-back as seen at the core boundary
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } reg_wb_t;

    // Store as seen at the core boundary, addr is a byte address
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_wr_t;

    localparam int          NUM_REGS    = 32;
    localparam int          DMEM_WORDS  = 64;
    localparam int          DMEM_IDX_W  = $clog2(DMEM_WORDS);
    localparam logic [31:0] RESET_PC    = 32'h0000_0000;

endpackage

/* hw/mips_isa_pkg.sv */
package mips_isa_pkg;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        BEQ    = 6'h04,
        ADDI   = 6'h08,
        ORI    = 6'h0d,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // Function codes for R_TYPE, instr[5:0]
    typedef enum logic [5:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

    // Field positions
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_W     = 16;
    localparam int TARGET_W  = 26;

    // Decodes as R_TYPE with an unknown funct, so nothing is written
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

endpackage

/* hw/mips_single_cycle.sv */
module mips_single_cycle
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    output reg_wb_t     wb,
    output mem_wr_t     st
);

    ctrl_t       ctrl;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  dest;
    logic [15:0] imm;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic        zero;
    logic [31:0] load_data;
    logic [31:0] write_data;

    assign rs  = instr[RS_LSB +: 5];
    assign rt  = instr[RT_LSB +: 5];
    assign rd  = instr[RD_LSB +: 5];
    assign imm = instr[IMM_W-1:0];

    pc_unit i_pc_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .branch (ctrl.branch),
        .jump   (ctrl.jump),
        .zero   (zero),
        .imm    (imm),
        .target (instr[TARGET_W-1:0]),
        .pc     (pc)
    );

    control_unit i_control_unit (
        .opcode (opcode_e'(instr[OP_LSB +: 6])),
        .funct  (funct_e'(instr[FUNCT_LSB +: 6])),
        .ctrl   (ctrl)
    );

    register_file i_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (rs),
        .rt      (rt),
        .rd      (dest),
        .we      (ctrl.reg_write),
        .wdata   (write_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu i_alu (
        .op       (ctrl.alu_op),
        .alu_src  (ctrl.alu_src),
        .imm_zext (ctrl.imm_zext),
        .a        (rs_data),
        .b        (rt_data),
        .imm      (imm),
        .result   (alu_result),
        .zero     (zero)
    );

    data_memory i_data_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (alu_result),
        .wdata (rt_data),
        .we    (ctrl.mem_write),
        .rdata (load_data)
    );

    // Write-back muxes
    assign dest       = ctrl.reg_dst ? rd : rt;
    assign write_data = ctrl.mem_to_reg ? load_data : alu_result;

    // Writes to r0 are dropped by the register file, so hide them here too
    assign wb.valid = ctrl.reg_write && (dest != 5'd0);
    assign wb.rd    = dest;
    assign wb.data  = write_data;

    assign st.en   = ctrl.mem_write;
    assign st.addr = alu_result;
    assign st.data = rt_data;

endmodule

/* hw/pc_unit.sv */
module pc_unit
    import mips_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        branch,
    input  logic        jump,
    input  logic        zero,
    input  logic [15:0] imm,
    input  logic [25:0] target,
    output logic [31:0] pc
);

    logic [31:0] pc_plus4;
    logic [31:0] branch_off;
    logic [31:0] pc_next;

    assign pc_plus4   = pc + 32'd4;
    assign branch_off = {{14{imm[15]}}, imm, 2'b00};

    always_comb begin
        if (jump) begin
            pc_next = {pc_plus4[31:28], target, 2'b00};
        end else if (branch && zero) begin
            pc_next = pc_plus4 + branch_off;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Instruction fetch assumes word-aligned pc at all times
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

/* hw/register_file.sv */
module register_file
    import mips_core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [NUM_REGS];

    // No bypass, a same-cycle read sees the old value
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    a_r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs == 5'd0 |-> rs_data == '0) and (rt == 5'd0 |-> rt_data == '0));

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_mips_single_cycle

output="$(./obj_dir/Vtb_mips_single_cycle 2>&1)" || true
echo "$output"

if grep -q "PASS: all tests" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* test/tb_mips_single_cycle.sv */
module tb_mips_single_cycle
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PROG_WORDS   = 128;
    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_CYCLES   = RESET_CYCLES + PROG_WORDS + 40;
    localparam logic [31:0] FINAL_PC     = 32'(4 * (PROG_WORDS - 1));

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    reg_wb_t     wb;
    mem_wr_t     st;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] shadow_regs [32];
    logic [31:0] shadow_mem [DMEM_WORDS];
    logic [31:0] exp_pc;
    logic [31:0] pc_after;
    reg_wb_t     exp_wb;
    mem_wr_t     exp_st;
    string       cur_name;
    int          cycles = 0;
    int          self_jumps = 0;

    mips_single_cycle i_mips_single_cycle (
        .clk   (clk),
        .rst_n (rst_n),
        .instr (instr),
        .pc    (pc),
        .wb    (wb),
        .st    (st)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped");
    endtask

    task automatic report_mismatch(input string check, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("Fail %s (%s): expected %h, actual %h", check, cur_name, expv, actv);
        stop_run();
    endtask

    function automatic logic [31:0] sign_ext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(0, 31));
    endfunction

    function automatic funct_e pick_funct();
        case ($urandom_range(0, 4))
            0:       return ADD;
            1:       return SUB;
            2:       return AND;
            3:       return OR;
            default: return SLT;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input funct_e f, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {R_TYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input int idx);
        return {J, 26'(idx)};
    endfunction

    // Control flow only moves forward, so the run always reaches the last word
    task automatic build_program();
        int         kind;
        int         reach;
        logic [4:0] ra;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind  = int'($urandom_range(0, 11));
            reach = (PROG_WORDS - 2 - i < 3) ? PROG_WORDS - 2 - i : 3;
            ra    = rand_reg();
            case (kind)
                0, 1, 2: prog[i] = enc_r(pick_funct(), ra, rand_reg(), rand_reg());
                3, 4:    prog[i] = enc_i(ADDI, ra, rand_reg(), 16'($urandom));
                5:       prog[i] = enc_i(ORI, ra, rand_reg(), 16'($urandom));
                6:       prog[i] = enc_i(LW, 5'd0, ra, 16'($urandom_range(0, 15) * 4));
                7, 8:    prog[i] = enc_i(SW, 5'd0, ra, 16'($urandom_range(0, 15) * 4));
                9: begin
                    // Same register half the time, so taken branches show up
                    prog[i] = enc_i(BEQ, ra, ($urandom_range(0, 1) != 0) ? ra : rand_reg(),
                                    16'($urandom_range(0, reach)));
                end
                10:      prog[i] = enc_j(i + 1 + int'($urandom_range(0, reach)));
                default: prog[i] = enc_i(ADDI, 5'd0, ra, 16'($urandom));
            endcase
        end
        prog[PROG_WORDS - 1] = enc_j(PROG_WORDS - 1);
    endtask

    task automatic write_back(input string name, input logic [4:0] dst,
                              input logic [31:0] val);
        cur_name     = name;
        exp_wb.valid = (dst != 5'd0);
        exp_wb.rd    = dst;
        exp_wb.data  = val;
        if (dst != 5'd0) begin
            shadow_regs[dst] = val;
        end
    endtask

    // Fetch at the DUT pc, then predict outputs and the following pc
    task automatic step_model();
        opcode_e     op;
        funct_e      fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        exp_pc   = pc_after;
        instr    = prog[pc[8:2]];
        op       = opcode_e'(instr[31:26]);
        fn       = funct_e'(instr[5:0]);
        a        = shadow_regs[instr[25:21]];
        b        = shadow_regs[instr[20:16]];
        ea       = a + sign_ext(instr[15:0]);
        exp_wb   = '0;
        exp_st   = '0;
        pc_after = exp_pc + 32'd4;
        case (op)
            R_TYPE: begin
                case (fn)
                    ADD:     write_back("add", instr[15:11], a + b);
                    SUB:     write_back("sub", instr[15:11], a - b);
                    AND:     write_back("and", instr[15:11], a & b);
                    OR:      write_back("or", instr[15:11], a | b);
                    SLT:     write_back("slt", instr[15:11],
                                        ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: cur_name = "nop";
                endcase
            end
            ADDI: write_back("addi", instr[20:16], ea);
            ORI:  write_back("ori", instr[20:16], a | {16'h0000, instr[15:0]});
            LW:   write_back("lw", instr[20:16], shadow_mem[ea[2 +: DMEM_IDX_W]]);
            SW: begin
                cur_name    = "sw";
                exp_st.en   = 1'b1;
                exp_st.addr = ea;
                exp_st.data = b;
                shadow_mem[ea[2 +: DMEM_IDX_W]] = b;
            end
            BEQ: begin
                cur_name = "beq";
                if (a == b) begin
                    pc_after = exp_pc + 32'd4 + (sign_ext(instr[15:0]) << 2);
                end
            end
            J: begin
                cur_name = "j";
                pc_after = {pc_after[31:28], instr[25:0], 2'b00};
                if (exp_pc == FINAL_PC) begin
                    self_jumps++;
                end
            end
            default: cur_name = "nop";
        endcase
    endtask

    a_pc: assert property (@(posedge clk) pc == exp_pc)
        else report_mismatch("pc", exp_pc, $sampled(pc));
    a_wb_valid: assert property (@(posedge clk) wb.valid == exp_wb.valid)
        else report_mismatch("wb valid", {31'd0, exp_wb.valid}, {31'd0, $sampled(wb.valid)});
    a_wb_rd: assert property (@(posedge clk) exp_wb.valid |-> wb.rd == exp_wb.rd)
        else report_mismatch("wb rd", {27'd0, exp_wb.rd}, {27'd0, $sampled(wb.rd)});
    a_wb_data: assert property (@(posedge clk) exp_wb.valid |-> wb.data == exp_wb.data)
        else report_mismatch("wb data", exp_wb.data, $sampled(wb.data));
    a_st_en: assert property (@(posedge clk) st.en == exp_st.en)
        else report_mismatch("store enable", {31'd0, exp_st.en}, {31'd0, $sampled(st.en)});
    a_st_addr: assert property (@(posedge clk) exp_st.en |-> st.addr == exp_st.addr)
        else report_mismatch("store addr", exp_st.addr, $sampled(st.addr));
    a_st_data: assert property (@(posedge clk) exp_st.en |-> st.data == exp_st.data)
        else report_mismatch("store data", exp_st.data, $sampled(st.data));

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: pc did not reach the final self-jump in %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    initial begin
        void'($urandom(43442));
        rst_n    = 1'b0;
        instr    = NOP_WORD;
        exp_pc   = RESET_PC;
        pc_after = RESET_PC;
        exp_wb   = '0;
        exp_st   = '0;
        cur_name = "reset";
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            shadow_mem[i] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Second pass over the self-jump confirms that it loops back
        while (self_jumps < 2) begin
            step_model();
            @(posedge clk);
            #1;
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule
